// File: cart_cmd_top.f
src/cart_cmd_pkg.sv
src/spi_byte_rx.sv
src/mcu_cmd.sv
src/sysclk_meter.sv
src/mem_req_gen.sv
src/cart_cmd_top.sv
tb/tb_cart_cmd_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_cart_cmd_top -f cart_cmd_top.f -o sim_cart_cmd
./obj_dir/sim_cart_cmd | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

// File: tb/tb_cart_cmd_top.sv
`timescale 1ns/100ps

module tb_cart_cmd_top;
  import cart_cmd_pkg::*;

  localparam int HALF    = 8;                  // clk cycles per sck phase
  localparam int BYTE_NS = 8 * 2 * HALF * 4;
  localparam int GAP     = 32;                 // idle cycles after each transaction

  typedef enum logic [3:0] {
    CHK_NONE, CHK_ADDR, CHK_ROM, CHK_SRM, CHK_SNES, CHK_MEM, CHK_GSU, CHK_FEAT,
    CHK_REGION, CHK_FREQ
  } chk_e;

  typedef struct packed {
    logic [3:0]  n;          // bytes in the transaction
    byte_t [0:7] tx;
    byte_t [0:7] exp_miso;
    logic [0:7]  miso_chk;   // miso bytes that are compared
    chk_e        kind;
    logic [31:0] val;
  } row_s;

  logic          clk = 1'b0;
  logic          snes_sysclk = 1'b0;
  logic          arst_n, sck, mosi, ss_n, miso;
  logic          mcu_rrq, mcu_wrq, mcu_rq_rdy, snescmd_we, region, gsu_reset;
  addr_t         mcu_addr;
  byte_t         mcu_data_out, mcu_data_in, snescmd_data_out, snescmd_data_in, featurebits;
  snescmd_addr_t snescmd_addr;
  mask_t         rom_mask, saveram_mask;

  byte_t mem [256];
  byte_t sram [512];
  row_s  rows [24];
  string names [24];
  int    nrows = 0;
  int    total_bytes = 0;
  logic  table_ready = 1'b0;
  int    row_errs = 0;
  int    ntests = 0;
  int    nfail = 0;

  cart_cmd_top i_dut (.*);

  always #2 clk = ~clk;
  always #20 snes_sysclk = ~snes_sysclk;  // 40 ns, 10 clk cycles

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // bit 8 folds into the upper nibble
  function automatic byte_t sram_fill(snescmd_addr_t a);
    return a[7:0] ^ {3'b000, a[8:4]};
  endfunction

  task automatic check_byte(input string what, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %02h, got %02h", what, exp, act);
      row_errs++;
    end
  endtask

  task automatic compare_addr(input string what, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %06h, got %06h", what, exp, act);
      row_errs++;
    end
  endtask

  task automatic verify_mask(input string what, input mask_t exp, input mask_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %06h, got %06h", what, exp, act);
      row_errs++;
    end
  endtask

  task automatic freq_within(input string what, input freq_t exp, input freq_t act,
                             input freq_t tol);
    if ($isunknown(act) || act + tol < exp || act > exp + tol) begin
      $display("ERROR %s: expected %0d +/- %0d, got %0d", what, exp, tol, act);
      row_errs++;
    end
  endtask

  task automatic add_row(input string name, input int n, input logic [63:0] data,
                         input chk_e kind, input logic [31:0] val);
    rows[nrows].n        = 4'(n);
    rows[nrows].tx       = data << (64 - 8 * n);  // first byte to the left
    rows[nrows].exp_miso = '0;
    rows[nrows].miso_chk = '0;
    rows[nrows].kind     = kind;
    rows[nrows].val      = val;
    names[nrows]         = name;
    nrows++;
    total_bytes += n;
  endtask

  task automatic want_miso(input int i, input byte_t v);
    rows[nrows - 1].exp_miso[i] = v;
    rows[nrows - 1].miso_chk[i] = 1'b1;
  endtask

  task automatic build_table();
    add_row("setaddr", 4, 64'h0012_3456, CHK_ADDR, 32'h12_3456);
    add_row("addr_hi_clr", 2, 64'h007e, CHK_ADDR, 32'h7e_0000);
    add_row("addr_rd", 4, 64'h0000_0040, CHK_ADDR, 32'h40);
    add_row("read_inc", 5, 64'h88_0000_0000, CHK_ADDR, 32'h45);
    want_miso(2, mem[8'h40]);  // result two bytes after its request
    want_miso(3, mem[8'h41]);
    want_miso(4, mem[8'h42]);
    add_row("addr_wr", 4, 64'h0000_0080, CHK_ADDR, 32'h80);
    add_row("write_inc", 4, 64'h9811_2233, CHK_MEM, 32'h80);
    add_row("rom_mask", 4, 64'h100f_ffff, CHK_ROM, 32'h0f_ffff);
    add_row("sram_mask", 4, 64'h2000_1fff, CHK_SRM, 32'h00_1fff);
    add_row("snes_addr", 3, 64'hd0_3401, CHK_SNES, 32'h134);
    add_row("snes_wr", 3, 64'hd2_5a00, CHK_SNES, 32'h135);
    add_row("snes_addr2", 3, 64'hd0_3401, CHK_SNES, 32'h134);
    add_row("snes_rdinc", 3, 64'hd1_0000, CHK_SNES, 32'h137);
    want_miso(1, 8'h5a);
    want_miso(2, sram_fill(9'h135));
    add_row("gsu_reset", 2, 64'heb00, CHK_GSU, 32'h0);
    add_row("feature", 2, 64'hed5c, CHK_FEAT, 32'h5c);
    add_row("region", 2, 64'hee01, CHK_REGION, 32'h1);
    add_row("signature", 2, 64'hf000, CHK_NONE, 32'h0);
    want_miso(1, 8'ha5);
    add_row("echo", 5, 64'hff_3cc3_6900, CHK_NONE, 32'h0);
    want_miso(2, 8'h3c);
    want_miso(3, 8'hc3);
    want_miso(4, 8'h69);
    add_row("freq", 6, 64'hfe00_0000_0000, CHK_FREQ, 32'd100);
    table_ready = 1'b1;
  endtask

  // mode 0, one transaction per row
  task automatic spi_xfer(input row_s row, output byte_t [0:7] got);
    got  = '0;
    ss_n = 1'b0;
    for (int k = 0; k < int'(row.n); k++) begin
      for (int i = 7; i >= 0; i--) begin
        mosi = row.tx[k][i];
        repeat (HALF) @(negedge clk);
        got[k][i] = miso;
        sck = 1'b1;
        repeat (HALF) @(negedge clk);
        sck = 1'b0;
      end
    end
    ss_n = 1'b1;
    repeat (GAP) @(negedge clk);
  endtask

  task automatic post_check(input int r, input byte_t [0:7] got);
    case (rows[r].kind)
      CHK_ADDR:   compare_addr(names[r], addr_t'(rows[r].val), mcu_addr);
      CHK_ROM:    verify_mask(names[r], mask_t'(rows[r].val), rom_mask);
      CHK_SRM:    verify_mask(names[r], mask_t'(rows[r].val), saveram_mask);
      CHK_SNES:   compare_addr(names[r], addr_t'(rows[r].val), addr_t'(snescmd_addr));
      CHK_GSU:    check_byte(names[r], byte_t'(rows[r].val), byte_t'(gsu_reset));
      CHK_FEAT:   check_byte(names[r], byte_t'(rows[r].val), featurebits);
      CHK_REGION: check_byte(names[r], byte_t'(rows[r].val), byte_t'(region));
      CHK_FREQ:   freq_within(names[r], rows[r].val, freq_t'(got[2:5]), freq_t'(1));
      CHK_MEM: begin
        for (int i = 1; i < int'(rows[r].n); i++)
          check_byte($sformatf("%s mem[%0d]", names[r], i - 1), rows[r].tx[i],
                     mem[rows[r].val[7:0] + 8'(i - 1)]);
      end
      default: ;
    endcase
  endtask

  task automatic tally_result(input string name);
    ntests++;
    if (row_errs == 0) begin
      $display("PASS %s", name);
    end else begin
      nfail++;
      $display("FAIL %s, %0d mismatches", name, row_errs);
    end
  endtask

  // memory and SNES command RAM models
  initial begin
    int          age;
    byte_t       rq_addr;
    logic [31:0] lfsr;
    mcu_rq_rdy      = 1'b0;
    mcu_data_in     = '0;
    snescmd_data_in = '0;
    age             = 99;
    rq_addr         = '0;
    lfsr            = 32'hc0ba_c786;
    for (int a = 0; a < 256; a++) begin
      for (int b = 0; b < 8; b++) begin
        lfsr   = lfsr_step(lfsr);
        mem[a] = {mem[a][6:0], lfsr[0]};
      end
    end
    for (int a = 0; a < 512; a++)
      sram[a] = sram_fill(9'(a));
    forever begin
      @(negedge clk);
      if (mcu_rrq || mcu_wrq) begin
        age     = 0;
        rq_addr = mcu_addr[7:0];
        if (mcu_wrq)
          mem[rq_addr] = mcu_data_out;
      end else if (age < 99) begin
        age++;
      end
      mcu_rq_rdy  = (age >= 5) && (age < 9);  // data held while ready
      mcu_data_in = mem[rq_addr];
      if (snescmd_we)
        sram[snescmd_addr] = snescmd_data_out;
      snescmd_data_in = sram[snescmd_addr];
    end
  end

  initial begin
    byte_t [0:7] got;
    arst_n = 1'b0;
    sck    = 1'b0;
    mosi   = 1'b0;
    ss_n   = 1'b1;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk);
    build_table();
    check_byte("reset gsu_reset", 8'h01, byte_t'(gsu_reset));
    check_byte("reset region", 8'h00, byte_t'(region));
    check_byte("reset featurebits", 8'h00, featurebits);
    check_byte("reset req pulses", 8'h00, {6'b0, mcu_rrq, mcu_wrq});
    check_byte("reset miso", 8'h00, byte_t'(miso));
    verify_mask("reset rom_mask", '0, rom_mask);
    verify_mask("reset saveram_mask", '0, saveram_mask);
    compare_addr("reset mcu_addr", '0, mcu_addr);
    tally_result("reset");
    for (int r = 0; r < nrows; r++) begin
      row_errs = 0;
      spi_xfer(rows[r], got);
      for (int i = 0; i < 8; i++) begin
        if (rows[r].miso_chk[i])
          check_byte($sformatf("%s miso[%0d]", names[r], i), rows[r].exp_miso[i], got[i]);
      end
      post_check(r, got);
      tally_result(names[r]);
    end
    $display("%0d tests run, %0d failed", ntests, nfail);
    if (nfail == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial begin
    wait (table_ready);
    #(2 * total_bytes * BYTE_NS);
    $display("watchdog expired before the last transaction finished");
    $display("tests failed");
    $finish;
  end

endmodule

// File: src/cart_cmd_top.sv
`timescale 1ns/100ps

module cart_cmd_top (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        sck,
  input  logic                        mosi,
  input  logic                        ss_n,
  output logic                        miso,
  input  logic                        snes_sysclk,
  output logic                        mcu_rrq,
  output logic                        mcu_wrq,
  output cart_cmd_pkg::addr_t         mcu_addr,
  output cart_cmd_pkg::byte_t         mcu_data_out,
  input  logic                        mcu_rq_rdy,
  input  cart_cmd_pkg::byte_t         mcu_data_in,
  output cart_cmd_pkg::snescmd_addr_t snescmd_addr,
  output cart_cmd_pkg::byte_t         snescmd_data_out,
  output logic                        snescmd_we,
  input  cart_cmd_pkg::byte_t         snescmd_data_in,
  output cart_cmd_pkg::mask_t         rom_mask,
  output cart_cmd_pkg::mask_t         saveram_mask,
  output cart_cmd_pkg::byte_t         featurebits,
  output logic                        region,
  output logic                        gsu_reset
);
  import cart_cmd_pkg::*;

  spi_byte_s rx;
  byte_t     resp_byte;
  mem_ctl_s  mem_ctl;
  mem_rsp_s  mem_rsp;
  freq_t     freq;

  spi_byte_rx i_spi_byte_rx (
    .clk       (clk),
    .arst_n    (arst_n),
    .sck       (sck),
    .mosi      (mosi),
    .ss_n      (ss_n),
    .miso      (miso),
    .rx        (rx),
    .resp_byte (resp_byte)
  );

  mcu_cmd i_mcu_cmd (
    .clk              (clk),
    .arst_n           (arst_n),
    .rx               (rx),
    .resp_byte        (resp_byte),
    .mem_ctl          (mem_ctl),
    .mem_rsp          (mem_rsp),
    .freq             (freq),
    .snescmd_addr     (snescmd_addr),
    .snescmd_data_out (snescmd_data_out),
    .snescmd_we       (snescmd_we),
    .snescmd_data_in  (snescmd_data_in),
    .rom_mask         (rom_mask),
    .saveram_mask     (saveram_mask),
    .featurebits      (featurebits),
    .region           (region),
    .gsu_reset        (gsu_reset)
  );

  sysclk_meter i_sysclk_meter (
    .clk    (clk),
    .arst_n (arst_n),
    .sysclk (snes_sysclk),
    .freq   (freq)
  );

  mem_req_gen i_mem_req_gen (
    .clk          (clk),
    .arst_n       (arst_n),
    .ctl          (mem_ctl),
    .rsp          (mem_rsp),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .mcu_data_out (mcu_data_out),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in)
  );

endmodule

// File: src/mem_req_gen.sv
`timescale 1ns/100ps

module mem_req_gen (
  input  logic                   clk,
  input  logic                   arst_n,
  input  cart_cmd_pkg::mem_ctl_s ctl,
  output cart_cmd_pkg::mem_rsp_s rsp,
  output logic                   mcu_rrq,
  output logic                   mcu_wrq,
  output cart_cmd_pkg::addr_t    mcu_addr,
  output cart_cmd_pkg::byte_t    mcu_data_out,
  input  logic                   mcu_rq_rdy,
  input  cart_cmd_pkg::byte_t    mcu_data_in
);
  import cart_cmd_pkg::*;

  logic [2:0] rdy_sr;
  logic       done;
  byte_t      rdata_q;

  // edge seen two cycles after rq_rdy rises
  assign done      = rdy_sr[1] & ~rdy_sr[2];
  assign rsp.done  = done;
  assign rsp.rdata = rdata_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_sr  <= '0;
      mcu_rrq <= 1'b0;
      mcu_wrq <= 1'b0;
    end else begin
      rdy_sr  <= {rdy_sr[1:0], mcu_rq_rdy};
      mcu_rrq <= ctl.rd_start;
      mcu_wrq <= ctl.wr_start;
    end
  end

  always_ff @(posedge clk) begin
    if (rdy_sr[0] && !rdy_sr[1])
      rdata_q <= mcu_data_in;  // ready with done
    if (ctl.wr_start)
      mcu_data_out <= ctl.wdata;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcu_addr <= '0;
    end else if (ctl.addr_load) begin
      case (ctl.addr_field)
        2'd0:    mcu_addr <= {ctl.load_data, 16'h0000};
        2'd1:    mcu_addr[15:8] <= ctl.load_data;
        default: mcu_addr[7:0] <= ctl.load_data;
      endcase
    end else if (done && ctl.auto_inc) begin
      mcu_addr <= mcu_addr + 24'd1;
    end
  end

endmodule

// File: src/sysclk_meter.sv
`timescale 1ns/100ps

module sysclk_meter (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                sysclk,
  output cart_cmd_pkg::freq_t freq
);
  import cart_cmd_pkg::*;

  logic [2:0] sys_sr;  // sync plus edge history
  logic       sys_rise;
  win_cnt_t   win_cnt;
  freq_t      edge_cnt;

  assign sys_rise = sys_sr[1] & ~sys_sr[2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sys_sr   <= '0;
      win_cnt  <= '0;
      edge_cnt <= '0;
      freq     <= '0;
    end else begin
      sys_sr <= {sys_sr[1:0], sysclk};
      if (win_cnt == win_cnt_t'(FREQ_WINDOW - 1)) begin
        win_cnt  <= '0;
        freq     <= edge_cnt;
        edge_cnt <= freq_t'(sys_rise);  // this edge opens the new window
      end else begin
        win_cnt <= win_cnt + 1'b1;
        if (sys_rise)
          edge_cnt <= edge_cnt + 32'd1;
      end
    end
  end

endmodule

// File: src/mcu_cmd.sv
`timescale 1ns/100ps

module mcu_cmd (
  input  logic                        clk,
  input  logic                        arst_n,
  input  cart_cmd_pkg::spi_byte_s     rx,
  output cart_cmd_pkg::byte_t         resp_byte,
  output cart_cmd_pkg::mem_ctl_s      mem_ctl,
  input  cart_cmd_pkg::mem_rsp_s      mem_rsp,
  input  cart_cmd_pkg::freq_t         freq,
  output cart_cmd_pkg::snescmd_addr_t snescmd_addr,
  output cart_cmd_pkg::byte_t         snescmd_data_out,
  output logic                        snescmd_we,
  input  cart_cmd_pkg::byte_t         snescmd_data_in,
  output cart_cmd_pkg::mask_t         rom_mask,
  output cart_cmd_pkg::mask_t         saveram_mask,
  output cart_cmd_pkg::byte_t         featurebits,
  output logic                        region,
  output logic                        gsu_reset
);
  import cart_cmd_pkg::*;

  byte_t cmd_q;
  byte_t cur_cmd;
  logic  strobe;
  logic  is_read;
  logic  is_write;
  freq_t freq_snap;

  // high byte first, counts 2..4
  function automatic mask_t put_byte(mask_t cur, cnt_t cnt, byte_t b);
    mask_t res;
    res = cur;
    case (cnt)
      8'd2:    res[23:16] = b;
      8'd3:    res[15:8] = b;
      8'd4:    res[7:0] = b;
      default: res = cur;
    endcase
    return res;
  endfunction

  assign strobe   = rx.cmd_ready | rx.param_ready;
  assign cur_cmd  = rx.cmd_ready ? rx.data : cmd_q;  // command byte not latched yet
  assign is_read  = (cmd_q[7:4] == CMD_READ);
  assign is_write = (cmd_q[7:4] == CMD_WRITE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      cmd_q <= '0;
    else if (rx.cmd_ready)
      cmd_q <= rx.data;
  end

  // request pulses are registered in mem_req_gen
  always_comb begin
    mem_ctl            = '0;
    mem_ctl.load_data  = rx.data;
    mem_ctl.wdata      = rx.data;
    mem_ctl.addr_field = rx.byte_cnt[1:0] - 2'd2;
    mem_ctl.auto_inc   = (is_read | is_write) & cmd_q[AUTO_INC_BIT];
    mem_ctl.addr_load  = rx.param_ready && (cmd_q[7:4] == CMD_SETADDR) &&
                         (rx.byte_cnt >= 8'd2) && (rx.byte_cnt <= 8'd4);
    mem_ctl.rd_start   = (rx.cmd_ready && rx.data[7:4] == CMD_READ) ||
                         (rx.param_ready && is_read);
    mem_ctl.wr_start   = rx.param_ready & is_write;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rom_mask     <= '0;
      saveram_mask <= '0;
      featurebits  <= '0;
      region       <= 1'b0;
      gsu_reset    <= 1'b1;
      snescmd_addr <= '0;
      snescmd_we   <= 1'b0;
    end else begin
      snescmd_we <= 1'b0;
      if (rx.param_ready) begin
        if (cmd_q[7:4] == CMD_ROMMASK)
          rom_mask <= put_byte(rom_mask, rx.byte_cnt, rx.data);
        if (cmd_q[7:4] == CMD_SRMMASK)
          saveram_mask <= put_byte(saveram_mask, rx.byte_cnt, rx.data);
        case (cmd_q)
          CMD_SNES_ADDR: begin
            if (rx.byte_cnt == 8'd2)
              snescmd_addr[7:0] <= rx.data;
            if (rx.byte_cnt == 8'd3)
              snescmd_addr[8] <= rx.data[0];
          end
          CMD_SNES_WR: begin
            if (rx.byte_cnt == 8'd2)
              snescmd_we <= 1'b1;
            if (rx.byte_cnt == 8'd3)
              snescmd_addr <= snescmd_addr + 9'd1;
          end
          CMD_GSU_RESET: gsu_reset <= rx.data[0];
          CMD_FEATURE:   featurebits <= rx.data;
          CMD_REGION:    region <= rx.data[0];
          default: ;
        endcase
      end
      // read pointer steps after every fetched byte
      if (strobe && cur_cmd == CMD_SNES_RDINC)
        snescmd_addr <= snescmd_addr + 9'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rx.param_ready && cmd_q == CMD_SNES_WR)
      snescmd_data_out <= rx.data;
    if (rx.cmd_ready && rx.data == CMD_FREQ)
      freq_snap <= freq;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_byte <= '0;
    end else if (mem_rsp.done && is_read) begin
      resp_byte <= mem_rsp.rdata;
    end else if (strobe) begin
      case (cur_cmd)
        CMD_SIG:        resp_byte <= SIGNATURE;
        CMD_ECHO:       resp_byte <= rx.data;
        CMD_SNES_RDINC: resp_byte <= snescmd_data_in;
        CMD_FREQ: begin
          case (rx.byte_cnt)
            8'd2:    resp_byte <= freq_snap[31:24];
            8'd3:    resp_byte <= freq_snap[23:16];
            8'd4:    resp_byte <= freq_snap[15:8];
            8'd5:    resp_byte <= freq_snap[7:0];
            default: resp_byte <= resp_byte;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

// File: src/spi_byte_rx.sv
`timescale 1ns/100ps

module spi_byte_rx (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    sck,
  input  logic                    mosi,
  input  logic                    ss_n,
  output logic                    miso,
  output cart_cmd_pkg::spi_byte_s rx,
  input  cart_cmd_pkg::byte_t     resp_byte
);
  import cart_cmd_pkg::*;

  logic [2:0] sck_sr;   // two sync stages plus one for edge detect
  logic [1:0] mosi_sr;
  logic [1:0] ss_sr;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;
  logic       byte_end;
  logic       cnt_upd;
  cnt_t       byte_cnt;
  byte_t      rx_sr;
  byte_t      tx_sr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_sr  <= '0;
      mosi_sr <= '0;
      ss_sr   <= 2'b11;
    end else begin
      sck_sr  <= {sck_sr[1:0], sck};
      mosi_sr <= {mosi_sr[0], mosi};
      ss_sr   <= {ss_sr[0], ss_n};
    end
  end

  assign sck_rise = sck_sr[1] & ~sck_sr[2];
  assign sck_fall = ~sck_sr[1] & sck_sr[2];

  // sample pipeline: edge -> byte_end -> count update -> strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      byte_end <= 1'b0;
      cnt_upd  <= 1'b0;
      byte_cnt <= '0;
    end else begin
      byte_end <= 1'b0;
      cnt_upd  <= byte_end;
      if (ss_sr[1]) begin  // deselected
        bit_cnt  <= '0;
        byte_cnt <= '0;
      end else begin
        if (sck_rise) begin
          bit_cnt  <= bit_cnt + 3'd1;
          byte_end <= (bit_cnt == 3'd7);
        end
        if (byte_end && byte_cnt != '1)
          byte_cnt <= byte_cnt + 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise)
      rx_sr <= {rx_sr[6:0], mosi_sr[1]};
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx <= '0;
    end else begin
      rx.cmd_ready   <= cnt_upd && (byte_cnt == 8'd1);
      rx.param_ready <= cnt_upd && (byte_cnt != 8'd1);
      if (cnt_upd) begin
        rx.data     <= rx_sr;
        rx.byte_cnt <= byte_cnt;
      end
    end
  end

  // response goes out during the following byte
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_sr <= '0;
    end else if (sck_fall) begin
      if (bit_cnt == 3'd0)
        tx_sr <= resp_byte;
      else
        tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign miso = tx_sr[7];

endmodule

// File: src/cart_cmd_pkg.sv
package cart_cmd_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [23:0] addr_t;
  typedef logic [23:0] mask_t;
  typedef logic [7:0]  cnt_t;    // saturates at 8'hff
  typedef logic [31:0] freq_t;
  typedef logic [8:0]  snescmd_addr_t;

  // sysclk measurement window in clk cycles
  localparam int FREQ_WINDOW = 1000;
  typedef logic [$clog2(FREQ_WINDOW)-1:0] win_cnt_t;

  // command nibbles (upper four bits of the command byte)
  localparam logic [3:0] CMD_SETADDR = 4'h0;
  localparam logic [3:0] CMD_ROMMASK = 4'h1;
  localparam logic [3:0] CMD_SRMMASK = 4'h2;
  localparam logic [3:0] CMD_READ    = 4'h8;
  localparam logic [3:0] CMD_WRITE   = 4'h9;

  // full command bytes
  localparam byte_t CMD_SNES_ADDR  = 8'hd0;
  localparam byte_t CMD_SNES_RDINC = 8'hd1;
  localparam byte_t CMD_SNES_WR    = 8'hd2;
  localparam byte_t CMD_GSU_RESET  = 8'heb;
  localparam byte_t CMD_FEATURE    = 8'hed;
  localparam byte_t CMD_REGION     = 8'hee;
  localparam byte_t CMD_SIG        = 8'hf0;
  localparam byte_t CMD_FREQ       = 8'hfe;
  localparam byte_t CMD_ECHO       = 8'hff;

  localparam byte_t SIGNATURE    = 8'ha5;
  localparam int    AUTO_INC_BIT = 3;

  typedef struct packed {
    logic  cmd_ready;
    logic  param_ready;
    byte_t data;
    cnt_t  byte_cnt;
  } spi_byte_s;

  typedef struct packed {
    logic       addr_load;
    logic [1:0] addr_field;  // 0 high (clears rest), 1 mid, 2 low
    byte_t      load_data;
    logic       rd_start;
    logic       wr_start;
    byte_t      wdata;
    logic       auto_inc;
  } mem_ctl_s;

  typedef struct packed {
    logic  done;
    byte_t rdata;
  } mem_rsp_s;

endpackage
